/* common/sdram_pkg.sv */
/*
 * Shared definitions for the SDR SDRAM controller: bus widths, command and
 * sequencer state encodings, and the mode-register word written at init.
 */
package sdram_pkg;

    localparam int DATA_W  = 16;
    localparam int DQM_W   = DATA_W / 8;
    localparam int ROW_W   = 13;
    localparam int BANK_W  = 2;
    localparam int COL_W   = 9;
    // Host word address is {row, bank, col}
    localparam int ADDR_W  = ROW_W + BANK_W + COL_W;
    localparam int TIMER_W = 16;

    typedef enum logic [2:0] {
        CMD_INHIBIT,
        CMD_NOP,
        CMD_ACTIVE,
        CMD_READ,
        CMD_WRITE,
        CMD_PRECHARGE,
        CMD_REFRESH,
        CMD_LOAD_MODE
    } sdram_cmd_t;

    typedef enum logic [3:0] {
        ST_PWRUP,
        ST_INIT_PRE,
        ST_INIT_REF1,
        ST_INIT_REF2,
        ST_LOAD_MODE,
        ST_IDLE,
        ST_REFRESH,
        ST_ACTIVE,
        ST_READ,
        ST_WRITE,
        ST_PRECHARGE
    } sdram_state_t;

    // ------------------------------
    // Mode register fields
    // ------------------------------
    localparam logic [2:0] MODE_BURST_LEN_1 = 3'b000;
    localparam logic       MODE_SEQUENTIAL  = 1'b0;

    // Burst write, standard operation, fixed burst of one word
    function automatic logic [ROW_W-1:0] mode_word(input int unsigned cas_latency);
        logic [ROW_W-1:0] w;
        w = '0;
        w[6:4] = 3'(cas_latency);
        w[3]   = MODE_SEQUENTIAL;
        w[2:0] = MODE_BURST_LEN_1;
        return w;
    endfunction

endpackage

/* hw/sdram_ctrl/sdram_cmd_fsm.sv */
/*
 * Command sequencer. Runs the power-up sequence, services owed refreshes
 * and turns each host request into ACTIVE, READ or WRITE, PRECHARGE-all.
 * Commands are issued on state entry and registered by the pin encoder.
 */
module sdram_cmd_fsm #(
    parameter int INIT_DELAY  = 10000,
    parameter int T_RP        = 3,
    parameter int T_RFC       = 7,
    parameter int T_MRD       = 2,
    parameter int T_RCD       = 3,
    parameter int CAS_LATENCY = 3
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          req,
    input  logic                          wr,
    input  logic [sdram_pkg::ADDR_W-1:0]  addr,
    input  logic [sdram_pkg::DATA_W-1:0]  wdata,
    input  logic                          refresh_owed,
    output logic                          accepted,
    output logic                          write_done,
    output sdram_pkg::sdram_cmd_t         cmd,
    output logic [sdram_pkg::ROW_W-1:0]   row,
    output logic [sdram_pkg::BANK_W-1:0]  bank,
    output logic [sdram_pkg::COL_W-1:0]   col,
    output logic                          a10,
    output logic                          refresh_ack,
    output logic                          init_done,
    output logic                          read_issued,
    output logic                          write_issued,
    output logic [sdram_pkg::DATA_W-1:0]  wdata_q
);

    sdram_pkg::sdram_state_t        state;
    sdram_pkg::sdram_state_t        next_state;
    logic [sdram_pkg::TIMER_W-1:0]  timer;
    logic                           first;
    logic                           timer_done;

    // Cycles spent in each state
    function automatic int state_len(input sdram_pkg::sdram_state_t s);
        case (s)
            sdram_pkg::ST_PWRUP:     return INIT_DELAY;
            sdram_pkg::ST_INIT_PRE,
            sdram_pkg::ST_PRECHARGE: return T_RP;
            sdram_pkg::ST_INIT_REF1,
            sdram_pkg::ST_INIT_REF2,
            sdram_pkg::ST_REFRESH:   return T_RFC;
            sdram_pkg::ST_LOAD_MODE: return T_MRD;
            sdram_pkg::ST_ACTIVE:    return T_RCD;
            default:                 return 1;
        endcase
    endfunction

    assign timer_done = (timer == '0);

    always_comb begin
        next_state = state;
        if (state == sdram_pkg::ST_IDLE) begin
            // Owed refresh wins over a waiting request
            if (refresh_owed) begin
                next_state = sdram_pkg::ST_REFRESH;
            end else if (req) begin
                next_state = sdram_pkg::ST_ACTIVE;
            end
        end else if (timer_done) begin
            case (state)
                sdram_pkg::ST_PWRUP:     next_state = sdram_pkg::ST_INIT_PRE;
                sdram_pkg::ST_INIT_PRE:  next_state = sdram_pkg::ST_INIT_REF1;
                sdram_pkg::ST_INIT_REF1: next_state = sdram_pkg::ST_INIT_REF2;
                sdram_pkg::ST_INIT_REF2: next_state = sdram_pkg::ST_LOAD_MODE;
                sdram_pkg::ST_ACTIVE: begin
                    next_state = wr ? sdram_pkg::ST_WRITE : sdram_pkg::ST_READ;
                end
                sdram_pkg::ST_READ,
                sdram_pkg::ST_WRITE:     next_state = sdram_pkg::ST_PRECHARGE;
                default:                 next_state = sdram_pkg::ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state        <= sdram_pkg::ST_PWRUP;
            timer        <= sdram_pkg::TIMER_W'(INIT_DELAY - 1);
            first        <= 1'b1;
            read_issued  <= 1'b0;
            write_issued <= 1'b0;
        end else begin
            state        <= next_state;
            first        <= (next_state != state);
            read_issued  <= (state == sdram_pkg::ST_READ);
            write_issued <= (state == sdram_pkg::ST_WRITE);
            if (next_state != state) begin
                timer <= sdram_pkg::TIMER_W'(state_len(next_state) - 1);
            end else if (!timer_done) begin
                timer <= timer - 1'b1;
            end
        end
    end

    // Write data for the pin cycle after acceptance
    always_ff @(posedge clk) begin
        if (accepted) begin
            wdata_q <= wdata;
        end
    end

    // ------------------------------
    // Command fields
    // ------------------------------
    always_comb begin
        cmd = sdram_pkg::CMD_NOP;
        if (state == sdram_pkg::ST_PWRUP) begin
            cmd = sdram_pkg::CMD_INHIBIT;
        end else if (first) begin
            case (state)
                sdram_pkg::ST_INIT_PRE,
                sdram_pkg::ST_PRECHARGE: cmd = sdram_pkg::CMD_PRECHARGE;
                sdram_pkg::ST_INIT_REF1,
                sdram_pkg::ST_INIT_REF2,
                sdram_pkg::ST_REFRESH:   cmd = sdram_pkg::CMD_REFRESH;
                sdram_pkg::ST_LOAD_MODE: cmd = sdram_pkg::CMD_LOAD_MODE;
                sdram_pkg::ST_ACTIVE:    cmd = sdram_pkg::CMD_ACTIVE;
                sdram_pkg::ST_READ:      cmd = sdram_pkg::CMD_READ;
                sdram_pkg::ST_WRITE:     cmd = sdram_pkg::CMD_WRITE;
                default:                 cmd = sdram_pkg::CMD_NOP;
            endcase
        end
    end

    // Host holds addr stable until accepted
    assign row  = (state == sdram_pkg::ST_LOAD_MODE) ? sdram_pkg::mode_word(CAS_LATENCY)
                                                     : addr[sdram_pkg::ADDR_W-1 -: sdram_pkg::ROW_W];
    assign bank = addr[sdram_pkg::COL_W +: sdram_pkg::BANK_W];
    assign col  = addr[sdram_pkg::COL_W-1:0];
    // Precharge all banks
    assign a10  = (cmd == sdram_pkg::CMD_PRECHARGE);

    assign accepted    = (state == sdram_pkg::ST_READ) || (state == sdram_pkg::ST_WRITE);
    assign write_done  = write_issued;
    assign refresh_ack = first && (state == sdram_pkg::ST_REFRESH);
    assign init_done   = (state inside {sdram_pkg::ST_IDLE, sdram_pkg::ST_REFRESH,
                                        sdram_pkg::ST_ACTIVE, sdram_pkg::ST_READ,
                                        sdram_pkg::ST_WRITE, sdram_pkg::ST_PRECHARGE});

    a_accept_pulse: assert property (@(posedge clk) disable iff (reset)
        accepted |=> !accepted);

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset)
        !(read_issued && write_issued));

endmodule

/* hw/sdram_ctrl/sdram_ctrl.sv */
/*
 * Close-page SDR SDRAM controller top level. Takes single-word host reads
 * and writes with a req/accepted handshake and drives a 16-bit SDRAM.
 * The data pad is split into dq_out, dq_oe and dq_in for the board level.
 */
module sdram_ctrl #(
    parameter int INIT_DELAY       = 10000,
    parameter int T_RP             = 3,
    parameter int T_RFC            = 7,
    parameter int T_MRD            = 2,
    parameter int T_RCD            = 3,
    parameter int CAS_LATENCY      = 3,
    parameter int REFRESH_INTERVAL = 780
) (
    input  logic                          clk,
    input  logic                          reset,

    // Host side
    input  logic                          req,
    input  logic                          wr,
    input  logic [sdram_pkg::ADDR_W-1:0]  addr,
    input  logic [sdram_pkg::DATA_W-1:0]  wdata,
    output logic                          accepted,
    output logic                          done,
    output logic [sdram_pkg::DATA_W-1:0]  rdata,

    // Memory side
    output logic                          sdram_clk,
    output logic                          cke,
    output logic                          cs_n,
    output logic                          ras_n,
    output logic                          cas_n,
    output logic                          we_n,
    output logic [sdram_pkg::BANK_W-1:0]  ba,
    output logic [sdram_pkg::ROW_W-1:0]   a,
    output logic [sdram_pkg::DQM_W-1:0]   dqm,
    output logic [sdram_pkg::DATA_W-1:0]  dq_out,
    output logic                          dq_oe,
    input  logic [sdram_pkg::DATA_W-1:0]  dq_in
);

    sdram_pkg::sdram_cmd_t          cmd;
    logic [sdram_pkg::ROW_W-1:0]    row;
    logic [sdram_pkg::BANK_W-1:0]   bank;
    logic [sdram_pkg::COL_W-1:0]    col;
    logic                           a10;
    logic                           refresh_owed;
    logic                           refresh_ack;
    logic                           init_done;
    logic                           read_issued;
    logic                           write_issued;
    logic                           write_done;
    logic                           read_done;
    logic [sdram_pkg::DATA_W-1:0]   wdata_q;

    assign sdram_clk = clk;
    assign done      = write_done | read_done;

    sdram_cmd_fsm #(
        .INIT_DELAY  (INIT_DELAY),
        .T_RP        (T_RP),
        .T_RFC       (T_RFC),
        .T_MRD       (T_MRD),
        .T_RCD       (T_RCD),
        .CAS_LATENCY (CAS_LATENCY)
    ) i_sdram_cmd_fsm (
        .clk, .reset, .req, .wr, .addr, .wdata, .refresh_owed,
        .accepted, .write_done, .cmd, .row, .bank, .col, .a10,
        .refresh_ack, .init_done, .read_issued, .write_issued, .wdata_q
    );

    sdram_refresh_timer #(
        .REFRESH_INTERVAL (REFRESH_INTERVAL)
    ) i_sdram_refresh_timer (
        .clk, .reset, .init_done, .refresh_ack, .refresh_owed
    );

    sdram_pin_encode i_sdram_pin_encode (
        .clk, .reset, .cmd, .row, .bank, .col, .a10,
        .cke, .cs_n, .ras_n, .cas_n, .we_n, .ba, .a, .dqm
    );

    sdram_rd_capture #(
        .CAS_LATENCY (CAS_LATENCY)
    ) i_sdram_rd_capture (
        .clk, .reset, .read_issued, .write_issued, .wdata_q, .dq_in,
        .read_done, .rdata, .dq_out, .dq_oe
    );

endmodule

/* hw/sdram_ctrl/sdram_pin_encode.sv */
/*
 * Registers the sequencer command onto the SDRAM control and address pins.
 * Every pin command appears one cycle after the state that issued it.
 */
module sdram_pin_encode (
    input  logic                          clk,
    input  logic                          reset,
    input  sdram_pkg::sdram_cmd_t         cmd,
    input  logic [sdram_pkg::ROW_W-1:0]   row,
    input  logic [sdram_pkg::BANK_W-1:0]  bank,
    input  logic [sdram_pkg::COL_W-1:0]   col,
    input  logic                          a10,
    output logic                          cke,
    output logic                          cs_n,
    output logic                          ras_n,
    output logic                          cas_n,
    output logic                          we_n,
    output logic [sdram_pkg::BANK_W-1:0]  ba,
    output logic [sdram_pkg::ROW_W-1:0]   a,
    output logic [sdram_pkg::DQM_W-1:0]   dqm
);

    logic [3:0]                   ctl;
    logic [sdram_pkg::ROW_W-1:0]  a_next;
    logic [sdram_pkg::BANK_W-1:0] ba_next;

    // {cs_n, ras_n, cas_n, we_n}
    always_comb begin
        ctl     = 4'b0111;
        a_next  = '0;
        ba_next = bank;
        case (cmd)
            sdram_pkg::CMD_INHIBIT:   ctl = 4'b1111;
            sdram_pkg::CMD_ACTIVE: begin
                ctl    = 4'b0011;
                a_next = row;
            end
            sdram_pkg::CMD_READ,
            sdram_pkg::CMD_WRITE: begin
                ctl = (cmd == sdram_pkg::CMD_READ) ? 4'b0101 : 4'b0100;
                a_next[sdram_pkg::COL_W-1:0] = col;
                a_next[10] = a10;
            end
            sdram_pkg::CMD_PRECHARGE: begin
                ctl        = 4'b0010;
                a_next[10] = a10;
            end
            sdram_pkg::CMD_REFRESH:   ctl = 4'b0001;
            sdram_pkg::CMD_LOAD_MODE: begin
                ctl     = 4'b0000;
                a_next  = row;
                ba_next = '0;
            end
            default:                  ctl = 4'b0111;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            {cs_n, ras_n, cas_n, we_n} <= 4'b1111;
            ba <= '0;
            a  <= '0;
        end else begin
            {cs_n, ras_n, cas_n, we_n} <= ctl;
            ba <= ba_next;
            a  <= a_next;
        end
    end

    // No clock suspend or byte masking
    assign cke = 1'b1;
    assign dqm = '0;

endmodule

/* hw/sdram_ctrl/sdram_rd_capture.sv */
/*
 * Read data return and write data drive. Tracks reads in flight for
 * CAS_LATENCY cycles after the READ pin cycle and returns dq_in then.
 */
module sdram_rd_capture #(
    parameter int CAS_LATENCY = 3
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          read_issued,
    input  logic                          write_issued,
    input  logic [sdram_pkg::DATA_W-1:0]  wdata_q,
    input  logic [sdram_pkg::DATA_W-1:0]  dq_in,
    output logic                          read_done,
    output logic [sdram_pkg::DATA_W-1:0]  rdata,
    output logic [sdram_pkg::DATA_W-1:0]  dq_out,
    output logic                          dq_oe
);

    // Bit n set means READ was on the pins n+1 cycles ago
    logic [CAS_LATENCY-1:0] valid_pipe;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[CAS_LATENCY-2:0], read_issued};
        end
    end

    assign read_done = valid_pipe[CAS_LATENCY-1];
    assign rdata     = read_done ? dq_in : '0;

    // Write data sits on the bus with the WRITE command
    assign dq_oe  = write_issued;
    assign dq_out = write_issued ? wdata_q : '0;

    a_no_bus_clash: assert property (@(posedge clk) disable iff (reset)
        !(dq_oe && (read_issued || (|valid_pipe))));

endmodule

/* hw/sdram_ctrl/sdram_refresh_timer.sv */
/*
 * Auto-refresh scheduler. Counts refresh intervals once init is done and
 * keeps the number of refreshes still owed by the sequencer.
 */
module sdram_refresh_timer #(
    parameter int REFRESH_INTERVAL = 780
) (
    input  logic clk,
    input  logic reset,
    input  logic init_done,
    input  logic refresh_ack,
    output logic refresh_owed
);

    localparam int CNT_W  = $clog2(REFRESH_INTERVAL + 1);
    localparam int OWED_W = 4;

    logic [CNT_W-1:0]  interval_cnt;
    logic [OWED_W-1:0] owed;
    logic              wrap;

    assign wrap = (interval_cnt == '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            interval_cnt <= CNT_W'(REFRESH_INTERVAL - 1);
            owed         <= '0;
        end else if (!init_done) begin
            interval_cnt <= CNT_W'(REFRESH_INTERVAL - 1);
            owed         <= '0;
        end else begin
            interval_cnt <= wrap ? CNT_W'(REFRESH_INTERVAL - 1) : interval_cnt - 1'b1;
            owed         <= owed + OWED_W'(wrap) - OWED_W'(refresh_ack);
        end
    end

    assign refresh_owed = (owed != '0);

    // Sequencer only acknowledges a refresh it was told about
    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        refresh_ack |-> owed != '0);

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the SDRAM controller testbench with Verilator
set -euo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sdram_ctrl -f sources.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "^TEST PASSED$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* sources.f */
common/sdram_pkg.sv
hw/sdram_ctrl/sdram_cmd_fsm.sv
hw/sdram_ctrl/sdram_refresh_timer.sv
hw/sdram_ctrl/sdram_pin_encode.sv
hw/sdram_ctrl/sdram_rd_capture.sv
hw/sdram_ctrl/sdram_ctrl.sv
test/sdram_model.sv
test/tb_sdram_ctrl.sv

/* test/sdram_model.sv */
/*
 * Behavioral SDR SDRAM for the controller testbench. Decodes the pin
 * commands, stores written words, returns read data CAS_LATENCY cycles
 * after READ, logs every command and counts command spacing violations.
 */
module sdram_model #(
    parameter int T_RP        = 3,
    parameter int T_RFC       = 7,
    parameter int T_MRD       = 2,
    parameter int T_RCD       = 3,
    parameter int CAS_LATENCY = 3
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        cke,
    input  logic        cs_n,
    input  logic        ras_n,
    input  logic        cas_n,
    input  logic        we_n,
    input  logic [1:0]  ba,
    input  logic [12:0] a,
    input  logic [1:0]  dqm,
    input  logic [15:0] dq_out,
    input  logic        dq_oe,
    output logic [15:0] dq_in
);

    localparam int LOG_MAX = 4096;

    // {cs_n, ras_n, cas_n, we_n}
    localparam logic [3:0] CTL_INHIBIT   = 4'b1111;
    localparam logic [3:0] CTL_NOP       = 4'b0111;
    localparam logic [3:0] CTL_ACTIVE    = 4'b0011;
    localparam logic [3:0] CTL_READ      = 4'b0101;
    localparam logic [3:0] CTL_WRITE     = 4'b0100;
    localparam logic [3:0] CTL_PRECHARGE = 4'b0010;
    localparam logic [3:0] CTL_REFRESH   = 4'b0001;
    localparam logic [3:0] CTL_LOAD_MODE = 4'b0000;

    logic [15:0] mem [int];
    logic [12:0] open_row [4];
    logic [3:0]  log_ctl [LOG_MAX];
    int          log_cycle [LOG_MAX];
    logic [12:0] log_a [LOG_MAX];
    logic [1:0]  log_ba [LOG_MAX];
    int          n_log;
    int          tick;
    int          refresh_count;
    int          violations;
    int          bus_errors;
    int          last_cycle;
    logic [3:0]  last_ctl;
    logic [12:0] last_act_row;
    logic [1:0]  last_act_ba;
    logic [12:0] last_rw_a;
    logic [1:0]  last_rw_ba;
    int          due_q [$];
    logic [15:0] data_q [$];

    // Never written locations read back a word built from the whole address
    function automatic logic [15:0] fill_word(input int key);
        return 16'(key) ^ 16'(key >> 8) ^ 16'h5a5a;
    endfunction

    function automatic int min_gap(input logic [3:0] ctl);
        case (ctl)
            CTL_ACTIVE:    return T_RCD;
            CTL_PRECHARGE: return T_RP;
            CTL_REFRESH:   return T_RFC;
            CTL_LOAD_MODE: return T_MRD;
            default:       return 1;
        endcase
    endfunction

    always @(posedge clk or posedge reset) begin
        logic [3:0] ctl;
        int         cyc;
        int         key;
        if (reset) begin
            tick          = 0;
            n_log         = 0;
            refresh_count = 0;
            violations    = 0;
            bus_errors    = 0;
            last_cycle    = -1000;
            last_ctl      = CTL_NOP;
            due_q.delete();
            data_q.delete();
            dq_in <= '0;
        end else begin
            // Pins seen here belong to the cycle that just ended
            cyc  = tick;
            tick = tick + 1;
            ctl  = cs_n ? CTL_INHIBIT : {1'b0, ras_n, cas_n, we_n};
            key  = int'({open_row[ba], ba, a[8:0]});
            if (ctl != CTL_INHIBIT && ctl != CTL_NOP) begin
                if (cyc - last_cycle < min_gap(last_ctl)) begin
                    violations++;
                    $display("Fail %0t: command %b at cycle %0d is %0d cycles after %b",
                             $time, ctl, cyc, cyc - last_cycle, last_ctl);
                end
                if (n_log < LOG_MAX) begin
                    log_ctl[n_log]   = ctl;
                    log_cycle[n_log] = cyc;
                    log_a[n_log]     = a;
                    log_ba[n_log]    = ba;
                    n_log++;
                end
                last_cycle = cyc;
                last_ctl   = ctl;
            end
            case (ctl)
                CTL_ACTIVE: begin
                    open_row[ba] = a;
                    last_act_row = a;
                    last_act_ba  = ba;
                end
                CTL_READ: begin
                    last_rw_a  = a;
                    last_rw_ba = ba;
                    due_q.push_back(tick + CAS_LATENCY - 1);
                    data_q.push_back(mem.exists(key) ? mem[key] : fill_word(key));
                end
                CTL_WRITE: begin
                    last_rw_a  = a;
                    last_rw_ba = ba;
                    mem[key]   = dq_out;
                    if (!dq_oe) begin
                        bus_errors++;
                        $display("WRITE at cycle %0d came without data on the bus", cyc);
                    end
                end
                CTL_REFRESH: refresh_count++;
                default: ;
            endcase
            if (dq_oe && ctl != CTL_WRITE) begin
                bus_errors++;
                $display("Controller drove the data bus at cycle %0d without a WRITE", cyc);
            end
            // Clock always enabled and no byte masking
            if (cke !== 1'b1 || dqm !== 2'b00) begin
                bus_errors++;
                $display("CKE low or DQM not zero at cycle %0d", cyc);
            end
            if (due_q.size() > 0 && due_q[0] == tick) begin
                dq_in <= data_q.pop_front();
                void'(due_q.pop_front());
            end else begin
                dq_in <= '0;
            end
        end
    end

endmodule

/* test/tb_sdram_ctrl.sv */
/*
 * Directed testbench for the SDRAM controller. Runs the init sequence,
 * single reads and writes, address mapping, read latency and refresh
 * checks against a behavioral SDRAM model.
 */
module tb_sdram_ctrl;

    localparam int INIT_DELAY       = 200;
    localparam int T_RP             = 3;
    localparam int T_RFC            = 7;
    localparam int T_MRD            = 2;
    localparam int T_RCD            = 3;
    localparam int CAS_LATENCY      = 3;
    localparam int REFRESH_INTERVAL = 390;
    // All tests together need roughly 11k cycles
    localparam int MAX_CYCLES       = 20000;

    // {cs_n, ras_n, cas_n, we_n}
    localparam logic [3:0] CTL_INHIBIT   = 4'b1111;
    localparam logic [3:0] CTL_READ      = 4'b0101;
    localparam logic [3:0] CTL_WRITE     = 4'b0100;
    localparam logic [3:0] CTL_PRECHARGE = 4'b0010;
    localparam logic [3:0] CTL_REFRESH   = 4'b0001;
    localparam logic [3:0] CTL_LOAD_MODE = 4'b0000;

    logic        clk;
    logic        reset;
    logic        req;
    logic        wr;
    logic [23:0] addr;
    logic [15:0] wdata;
    logic        accepted;
    logic        done;
    logic [15:0] rdata;
    logic        sdram_clk;
    logic        cke;
    logic        cs_n;
    logic        ras_n;
    logic        cas_n;
    logic        we_n;
    logic [1:0]  ba;
    logic [12:0] a;
    logic [1:0]  dqm;
    logic [15:0] dq_out;
    logic        dq_oe;
    logic [15:0] dq_in;

    int          cycle;
    int          errors;
    int          accesses;
    int          sdram_clk_edges;
    logic [15:0] expect_mem [int];
    logic [23:0] mapped_addrs [$];

    sdram_ctrl #(
        .INIT_DELAY (INIT_DELAY), .T_RP (T_RP), .T_RFC (T_RFC), .T_MRD (T_MRD),
        .T_RCD (T_RCD), .CAS_LATENCY (CAS_LATENCY), .REFRESH_INTERVAL (REFRESH_INTERVAL)
    ) i_sdram_ctrl (
        .clk, .reset, .req, .wr, .addr, .wdata, .accepted, .done, .rdata,
        .sdram_clk, .cke, .cs_n, .ras_n, .cas_n, .we_n, .ba, .a, .dqm,
        .dq_out, .dq_oe, .dq_in
    );

    sdram_model #(
        .T_RP (T_RP), .T_RFC (T_RFC), .T_MRD (T_MRD), .T_RCD (T_RCD),
        .CAS_LATENCY (CAS_LATENCY)
    ) i_model (
        .clk, .reset, .cke, .cs_n, .ras_n, .cas_n, .we_n, .ba, .a, .dqm,
        .dq_out, .dq_oe, .dq_in
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("Timeout: the run went past %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic note_error(input string msg);
        errors++;
        $display("Fail %0t: %s", $time, msg);
    endtask

    // Memory clock must rise together with clk
    always @(posedge sdram_clk) begin
        sdram_clk_edges++;
        if (clk !== 1'b1)
            note_error("sdram_clk rose while clk was low");
    end

    // CAS latency in bits 6:4, everything else zero
    function automatic logic [12:0] expected_mode_word(input int cl);
        logic [12:0] w;
        w = '0;
        w[6:4] = 3'(cl);
        return w;
    endfunction

    task automatic check_reset_state();
        if (accepted || done || rdata != '0 || dq_oe)
            note_error("host or data outputs not idle in reset");
        if (!cke || {cs_n, ras_n, cas_n, we_n} != CTL_INHIBIT)
            note_error("control pins not at INHIBIT in reset");
    endtask

    task automatic check_init_sequence();
        while (i_model.n_log < 4) @(negedge clk);
        if (i_model.log_cycle[0] < INIT_DELAY)
            note_error($sformatf("first command at cycle %0d", i_model.log_cycle[0]));
        if (i_model.log_ctl[0] != CTL_PRECHARGE || !i_model.log_a[0][10])
            note_error("init does not open with PRECHARGE-all");
        if (i_model.log_ctl[1] != CTL_REFRESH || i_model.log_ctl[2] != CTL_REFRESH)
            note_error("init lacks two REFRESH commands");
        if (i_model.log_ctl[3] != CTL_LOAD_MODE)
            note_error("fourth init command is not LOAD_MODE");
        if (i_model.log_a[3] != expected_mode_word(CAS_LATENCY) || i_model.log_ba[3] != 2'b00)
            note_error($sformatf("mode word %h", i_model.log_a[3]));
    endtask

    // One access with handshake, latency and address field checks
    task automatic host_access(input logic is_wr, input logic [23:0] word_addr,
                               input logic [15:0] data, output logic [15:0] rd);
        logic [3:0] ctl_seen;
        rd = '0;
        accesses++;
        @(posedge clk);
        req   <= 1'b1;
        wr    <= is_wr;
        addr  <= word_addr;
        wdata <= data;
        do @(posedge clk); while (!accepted);
        req <= 1'b0;
        @(posedge clk);
        ctl_seen = {cs_n, ras_n, cas_n, we_n};
        if (accepted)
            note_error("accepted high for two cycles");
        if (ctl_seen != (is_wr ? CTL_WRITE : CTL_READ))
            note_error($sformatf("pins show %b the cycle after accepted", ctl_seen));
        if (is_wr && !done)
            note_error("no done with the WRITE command");
        if (!is_wr) begin
            if (done)
                note_error("read done with the READ command");
            repeat (CAS_LATENCY - 1) begin
                @(posedge clk);
                if (done)
                    note_error("read done ahead of the CAS latency");
            end
            @(posedge clk);
            if (!done)
                note_error("no read done CAS_LATENCY cycles after READ");
            rd = rdata;
        end
        @(negedge clk);
        if (i_model.last_act_row != word_addr[23:11] || i_model.last_act_ba != word_addr[10:9])
            note_error($sformatf("ACTIVE row/bank wrong for %h", word_addr));
        if (i_model.last_rw_a[8:0] != word_addr[8:0] || i_model.last_rw_ba != word_addr[10:9])
            note_error($sformatf("READ/WRITE column wrong for %h", word_addr));
    endtask

    task automatic write_word(input logic [23:0] word_addr, input logic [15:0] data);
        logic [15:0] rd;
        host_access(1'b1, word_addr, data, rd);
        expect_mem[int'(word_addr)] = data;
    endtask

    task automatic read_and_compare(input logic [23:0] word_addr);
        logic [15:0] rd;
        host_access(1'b0, word_addr, '0, rd);
        if (rd !== expect_mem[int'(word_addr)])
            note_error($sformatf("read %h gave %h, expected %h", word_addr, rd,
                                 expect_mem[int'(word_addr)]));
    endtask

    task automatic write_read_back();
        write_word(24'h12_3456, 16'hbeef);
        read_and_compare(24'h12_3456);
    endtask

    task automatic random_mapping();
        logic [23:0] word_addr;
        repeat (20) begin
            word_addr = 24'($urandom());
            mapped_addrs.push_back(word_addr);
            write_word(word_addr, 16'($urandom()));
        end
        foreach (mapped_addrs[i]) read_and_compare(mapped_addrs[i]);
    endtask

    task automatic check_refresh_count(input int r0, input int c0);
        int refs;
        int expected;
        refs     = i_model.refresh_count - r0;
        expected = (cycle - c0) / REFRESH_INTERVAL;
        if (refs < expected - 1 || refs > expected + 1)
            note_error($sformatf("%0d refreshes in %0d cycles", refs, cycle - c0));
    endtask

    task automatic idle_refresh();
        int r0;
        int c0;
        @(negedge clk);
        r0 = i_model.refresh_count;
        c0 = cycle;
        repeat (4000) @(posedge clk);
        @(negedge clk);
        check_refresh_count(r0, c0);
    endtask

    task automatic traffic_refresh();
        int r0;
        int c0;
        @(negedge clk);
        r0 = i_model.refresh_count;
        c0 = cycle;
        while (cycle - c0 < 4000) begin
            if ($urandom() % 2 == 0)
                write_word(24'($urandom()), 16'($urandom()));
            else
                read_and_compare(mapped_addrs[$urandom() % mapped_addrs.size()]);
        end
        check_refresh_count(r0, c0);
        // Earlier data survives the refreshes
        foreach (mapped_addrs[i]) read_and_compare(mapped_addrs[i]);
    endtask

    task automatic check_spacing();
        if (i_model.violations != 0)
            note_error($sformatf("%0d command spacing violations", i_model.violations));
        if (i_model.bus_errors != 0)
            note_error($sformatf("%0d data bus errors", i_model.bus_errors));
    endtask

    task automatic check_clock_forward();
        @(negedge clk);
        if (sdram_clk_edges != cycle)
            note_error($sformatf("sdram_clk rose %0d times in %0d cycles",
                                 sdram_clk_edges, cycle));
    endtask

    initial begin
        clk             = 1'b0;
        reset           = 1'b1;
        req             = 1'b0;
        wr              = 1'b0;
        addr            = '0;
        wdata           = '0;
        cycle           = 0;
        errors          = 0;
        accesses        = 0;
        sdram_clk_edges = 0;
        void'($urandom(34));
        repeat (16) @(posedge clk);
        check_reset_state();
        reset <= 1'b0;
        check_init_sequence();
        write_read_back();
        random_mapping();
        idle_refresh();
        traffic_refresh();
        check_spacing();
        check_clock_forward();
        $display("Summary: %0d accesses, %0d errors, %0d spacing violations, %0d bus errors",
                 accesses, errors, i_model.violations, i_model.bus_errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
